// File: cache_req_checker.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module cache_req_checker (
  input  logic                            ap_clk,
  input  logic                            control_areset,
  input  logic [`GLAY_NUM_REQUESTORS-1:0] mem_req_valid,
  input  glay_memory_pkg::glay_addr_t     mem_req_base_address   [`GLAY_NUM_REQUESTORS],
  input  glay_memory_pkg::glay_addr_t     mem_req_address_offset [`GLAY_NUM_REQUESTORS],
  input  logic [`GLAY_NUM_REQUESTORS-1:0] mem_req_grant,
  input  logic                            cache_req_valid,
  input  glay_memory_pkg::glay_addr_t     cache_req_addr,
  input  glay_memory_pkg::glay_req_id_t   cache_req_id,
  input  logic                            fifo_setup_signal,
  input  int                              test_num,
  input  logic                            test_done,
  input  logic                            check_en,
  input  int                              expect_issues,
  input  int                              expect_grants,
  output int                              test_issues,
  output int                              test_grants,
  output int                              pending,
  output int                              error_count,
  output int                              match_count
);
  import glay_memory_pkg::*;

  // Expected requests in grant order
  glay_addr_t   exp_addr_q [$];
  glay_req_id_t exp_id_q   [$];

  int test_errors;
  int test_matches;
  int setup_cycles;
  int last_winner;

  // Reference address, base plus offset modulo 2**width
  function automatic glay_addr_t expected_addr(glay_addr_t base, glay_addr_t offset);
    logic [`GLAY_ADDR_WIDTH:0] full_sum;
    full_sum = {1'b0, base} + {1'b0, offset};
    return full_sum[`GLAY_ADDR_WIDTH-1:0];
  endfunction

  function automatic string test_name(int n);
    case (n)
      1:       return "reset_and_setup";
      2:       return "random_traffic";
      3:       return "round_robin";
      4:       return "credit_limit";
      5:       return "enable_gate";
      6:       return "fifo_backpressure";
      default: return "idle";
    endcase
  endfunction

  task automatic flag_value(string what, logic [63:0] expected, logic [63:0] actual);
    $display("CHECK FAILED %s %s expected 0x%0h actual 0x%0h",
             test_name(test_num), what, expected, actual);
    test_errors++;
    error_count++;
  endtask

  task automatic flag_event(string msg);
    $display("%s: %s", test_name(test_num), msg);
    test_errors++;
    error_count++;
  endtask

  // ------------------------------
  // Sampling at each rising edge
  // ------------------------------
  always @(posedge ap_clk) begin
    int           winner;
    glay_addr_t   exp_a;
    glay_req_id_t exp_i;
    if (control_areset) begin
      exp_addr_q.delete();
      exp_id_q.delete();
      last_winner = -1;
      setup_cycles = 0;
    end else begin
      if (fifo_setup_signal) begin
        if (test_num == 1) begin
          setup_cycles++;
        end
        if ((|mem_req_grant) || cache_req_valid) begin
          flag_event("grant or cache request while setup is running");
        end
      end
      // Grant edge, payload still held by the requestor
      if (|mem_req_grant) begin
        winner = 0;
        for (int i = 0; i < `GLAY_NUM_REQUESTORS; i++) begin
          if (mem_req_grant[i]) winner = i;
        end
        // Both holding means the other one is due
        if ((&mem_req_valid) && (last_winner >= 0) && (winner == last_winner)) begin
          flag_value("grant requestor", (last_winner + 1) % `GLAY_NUM_REQUESTORS, winner);
        end
        exp_addr_q.push_back(expected_addr(mem_req_base_address[winner],
                                           mem_req_address_offset[winner]));
        exp_id_q.push_back(glay_req_id_t'(winner));
        last_winner = winner;
        test_grants++;
      end
      // Cache side, oldest expected entry first
      if (cache_req_valid) begin
        test_issues++;
        if (exp_addr_q.size() == 0) begin
          flag_event("cache request arrived with no granted request waiting");
        end else begin
          exp_a = exp_addr_q.pop_front();
          exp_i = exp_id_q.pop_front();
          if (cache_req_addr !== exp_a) begin
            flag_value("cache_req_addr", exp_a, cache_req_addr);
          end else if (cache_req_id !== exp_i) begin
            flag_value("cache_req_id", exp_i, cache_req_id);
          end else begin
            test_matches++;
            match_count++;
          end
        end
      end
      // Count checkpoints requested by the test sequence
      if (check_en) begin
        if (test_issues != expect_issues) begin
          flag_value("issue count", expect_issues, test_issues);
        end
        if ((expect_grants >= 0) && (test_grants != expect_grants)) begin
          flag_value("grant count", expect_grants, test_grants);
        end
      end
      if (test_done) begin
        if (exp_addr_q.size() != 0) begin
          flag_event("granted requests never reached the cache");
        end
        if ((test_num == 1) && (setup_cycles != `GLAY_SETUP_CYCLES)) begin
          flag_value("setup cycles", `GLAY_SETUP_CYCLES, setup_cycles);
        end
        $display("test %0d %s: %s, %0d matched, %0d errors", test_num, test_name(test_num),
                 (test_errors == 0) ? "ok" : "mismatches", test_matches, test_errors);
        test_errors = 0;
        test_matches = 0;
        test_issues = 0;
        test_grants = 0;
      end
    end
    pending = exp_addr_q.size();
  end

endmodule : cache_req_checker

// File: cache_request_config.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module cache_request_config (
  input  logic                          ap_clk,
  input  logic                          control_areset,
  input  logic                          cfg_wr_en,
  input  glay_control_pkg::glay_cfg_reg_e cfg_addr,
  input  logic [`GLAY_ADDR_WIDTH-1:0]   cfg_wdata,
  output logic                          enable,
  output logic [`GLAY_CREDIT_WIDTH-1:0] credit_limit,
  output logic                          credit_load,
  output logic                          setup_busy
);
  import glay_control_pkg::*;

  localparam int SETUP_W = $clog2(`GLAY_SETUP_CYCLES);
  localparam logic [`GLAY_CREDIT_WIDTH-1:0] LIMIT_MAX = `GLAY_CREDIT_WIDTH'(`GLAY_MAX_OUTSTANDING);

  glay_setup_state_e   setup_state;
  logic [SETUP_W-1:0]  setup_count;

  // ------------------------------
  // Host register writes
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      enable       <= 1'b0;
      credit_limit <= LIMIT_MAX;
      credit_load  <= 1'b0;
    end else begin
      // Load strobe lines up with the new limit value
      credit_load <= cfg_wr_en && (cfg_addr == REG_CREDIT_LIMIT);
      if (cfg_wr_en && (cfg_addr == REG_CONTROL)) begin
        enable <= cfg_wdata[0];
      end
      if (cfg_wr_en && (cfg_addr == REG_CREDIT_LIMIT)) begin
        // Saturate above max, zero would deadlock so force 1
        if (cfg_wdata > `GLAY_ADDR_WIDTH'(`GLAY_MAX_OUTSTANDING)) begin
          credit_limit <= LIMIT_MAX;
        end else if (cfg_wdata == '0) begin
          credit_limit <= `GLAY_CREDIT_WIDTH'(1);
        end else begin
          credit_limit <= cfg_wdata[`GLAY_CREDIT_WIDTH-1:0];
        end
      end
    end
  end

  // ------------------------------
  // Setup sequence after reset
  // ------------------------------
  // CLEAR takes one cycle, WAIT covers the rest of the period
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      setup_state <= SETUP_CLEAR;
      setup_count <= '0;
    end else begin
      unique case (setup_state)
        SETUP_CLEAR: begin
          setup_count <= SETUP_W'(`GLAY_SETUP_CYCLES - 2);
          setup_state <= SETUP_WAIT;
        end
        SETUP_WAIT: begin
          if (setup_count == '0) begin
            setup_state <= SETUP_DONE;
          end else begin
            setup_count <= setup_count - 1'b1;
          end
        end
        default: setup_state <= SETUP_DONE;
      endcase
    end
  end

  // Busy through reset and until the walk completes
  assign setup_busy = (setup_state != SETUP_DONE);

endmodule : cache_request_config

// File: cache_request_generator.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module cache_request_generator (
  input  logic                            ap_clk,
  input  logic                            control_areset,
  input  logic [`GLAY_NUM_REQUESTORS-1:0] mem_req_valid,
  input  glay_memory_pkg::glay_addr_t     mem_req_base_address   [`GLAY_NUM_REQUESTORS],
  input  glay_memory_pkg::glay_addr_t     mem_req_address_offset [`GLAY_NUM_REQUESTORS],
  output logic [`GLAY_NUM_REQUESTORS-1:0] mem_req_grant,
  input  logic                            cfg_wr_en,
  input  glay_control_pkg::glay_cfg_reg_e cfg_addr,
  input  logic [`GLAY_ADDR_WIDTH-1:0]     cfg_wdata,
  output logic                            cache_req_valid,
  output glay_memory_pkg::glay_addr_t     cache_req_addr,
  output glay_memory_pkg::glay_req_id_t   cache_req_id,
  input  logic                            cache_resp_valid,
  output logic                            fifo_setup_signal
);
  import glay_memory_pkg::*;

  // Config outputs
  logic                          enable;
  logic [`GLAY_CREDIT_WIDTH-1:0] credit_limit;
  logic                          credit_load;
  logic                          setup_busy;

  // Arbiter winner
  logic         win_valid;
  glay_req_id_t win_id;
  glay_addr_t   win_base;
  glay_addr_t   win_offset;

  // Address stage
  logic         addr_valid;
  glay_req_id_t addr_id;
  glay_addr_t   addr_sum;

  // FIFO and tracker
  glay_req_id_t fifo_rd_id;
  glay_addr_t   fifo_rd_addr;
  logic         fifo_empty;
  logic         fifo_almost_full;
  logic         stall;
  logic         issue;

  cache_request_config u_config (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .cfg_wr_en      (cfg_wr_en),
    .cfg_addr       (cfg_addr),
    .cfg_wdata      (cfg_wdata),
    .enable         (enable),
    .credit_limit   (credit_limit),
    .credit_load    (credit_load),
    .setup_busy     (setup_busy)
  );

  // ------------------------------
  // Arbitration
  // ------------------------------
  // No grants during setup or when the queue is close to full
  request_arbiter u_arbiter (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .hold_off       (setup_busy | fifo_almost_full),
    .req_valid      (mem_req_valid),
    .req_base       (mem_req_base_address),
    .req_offset     (mem_req_address_offset),
    .grant          (mem_req_grant),
    .win_valid      (win_valid),
    .win_id         (win_id),
    .win_base       (win_base),
    .win_offset     (win_offset)
  );

  // ------------------------------
  // Address stage
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      addr_valid <= 1'b0;
    end else begin
      addr_valid <= win_valid;
    end
  end

  // Sum wraps at the address width
  always_ff @(posedge ap_clk) begin
    addr_sum <= win_base + win_offset;
    addr_id  <= win_id;
  end

  request_fifo u_fifo (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .wr_en          (addr_valid),
    .wr_id          (addr_id),
    .wr_addr        (addr_sum),
    .rd_en          (issue),
    .rd_id          (fifo_rd_id),
    .rd_addr        (fifo_rd_addr),
    .empty          (fifo_empty),
    .almost_full    (fifo_almost_full)
  );

  // ------------------------------
  // Issue to cache
  // ------------------------------
  assign issue = !fifo_empty && enable && !stall;

  outstanding_tracker u_tracker (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .credit_load    (credit_load),
    .credit_limit   (credit_limit),
    .issue          (issue),
    .response       (cache_resp_valid),
    .stall          (stall)
  );

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      cache_req_valid <= 1'b0;
    end else begin
      cache_req_valid <= issue;
    end
  end

  // Head entry latched on the pop
  always_ff @(posedge ap_clk) begin
    if (issue) begin
      cache_req_addr <= fifo_rd_addr;
      cache_req_id   <= fifo_rd_id;
    end
  end

  assign fifo_setup_signal = setup_busy;

endmodule : cache_request_generator

// File: flist.f
+incdir+.
glay_memory_pkg.sv
glay_control_pkg.sv
cache_request_config.sv
request_arbiter.sv
request_fifo.sv
outstanding_tracker.sv
cache_request_generator.sv
glay_asserts.sv
cache_req_checker.sv
tb_cache_request_generator.sv

// File: glay_asserts.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module glay_asserts (
  input logic                            ap_clk,
  input logic                            control_areset,
  input logic [`GLAY_NUM_REQUESTORS-1:0] mem_req_grant,
  input logic                            fifo_setup_signal,
  input logic                            cache_req_valid
);

  // ------------------------------
  // Grant and reset rules
  // ------------------------------
  grant_onehot: assert property (@(posedge ap_clk) disable iff (control_areset)
    $onehot0(mem_req_grant))
    else $error("more than one requestor granted in one cycle");

  // Setup period keeps the arbiter quiet
  no_grant_in_setup: assert property (@(posedge ap_clk)
    fifo_setup_signal |-> (mem_req_grant == '0))
    else $error("grant issued while setup is running");

  // Registered cache strobe cleared by the reset
  quiet_in_reset: assert property (@(posedge ap_clk)
    (control_areset && $past(control_areset)) |-> !cache_req_valid)
    else $error("cache request seen during reset");

endmodule : glay_asserts

bind cache_request_generator glay_asserts u_asserts (
  .ap_clk            (ap_clk),
  .control_areset    (control_areset),
  .mem_req_grant     (mem_req_grant),
  .fifo_setup_signal (fifo_setup_signal),
  .cache_req_valid   (cache_req_valid)
);

// File: glay_control_pkg.sv
package glay_control_pkg;

  // ------------------------------
  // Control and setup types
  // ------------------------------

  // Post-reset setup walk
  typedef enum logic [1:0] {
    SETUP_CLEAR = 2'd0,
    SETUP_WAIT  = 2'd1,
    SETUP_DONE  = 2'd2
  } glay_setup_state_e;

  // Host register map, bit 0 of REG_CONTROL is enable
  typedef enum logic {
    REG_CONTROL      = 1'b0,
    REG_CREDIT_LIMIT = 1'b1
  } glay_cfg_reg_e;

endpackage : glay_control_pkg

// File: glay_memory_pkg.sv
`include "glay_params.svh"

package glay_memory_pkg;

  // ------------------------------
  // Memory request types
  // ------------------------------

  // Byte address as seen by the cache
  typedef logic [`GLAY_ADDR_WIDTH-1:0] glay_addr_t;

  // Requestor index, tags each request through the queue
  typedef logic [0:0] glay_req_id_t;

endpackage : glay_memory_pkg

// File: glay_params.svh
`ifndef GLAY_PARAMS_SVH
`define GLAY_PARAMS_SVH

// Requestor count and address width
`define GLAY_NUM_REQUESTORS 2
`define GLAY_ADDR_WIDTH 32

// Request FIFO sizing
`define GLAY_FIFO_DEPTH 8
// Free entries kept back for requests still in the arbiter and address stages
`define GLAY_FIFO_MARGIN 3

// Outstanding-transaction credits
`define GLAY_MAX_OUTSTANDING 16
`define GLAY_CREDIT_WIDTH $clog2(`GLAY_MAX_OUTSTANDING + 1)

// Post-reset setup period, in cycles
`define GLAY_SETUP_CYCLES 8

`endif

// File: outstanding_tracker.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module outstanding_tracker (
  input  logic                          ap_clk,
  input  logic                          control_areset,
  input  logic                          credit_load,
  input  logic [`GLAY_CREDIT_WIDTH-1:0] credit_limit,
  input  logic                          issue,
  input  logic                          response,
  output logic                          stall
);

  // Free credits left
  logic [`GLAY_CREDIT_WIDTH-1:0] credits;

  // ------------------------------
  // Saturating credit counter
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      credits <= `GLAY_CREDIT_WIDTH'(`GLAY_MAX_OUTSTANDING);
    end else if (credit_load) begin
      // New limit wins over any same-cycle traffic
      credits <= credit_limit;
    end else begin
      unique case ({issue, response})
        2'b10: begin
          if (credits != '0) begin
            credits <= credits - 1'b1;
          end
        end
        2'b01: begin
          // Never above the programmed limit
          if (credits < credit_limit) begin
            credits <= credits + 1'b1;
          end
        end
        default: credits <= credits; // both or neither cancel out
      endcase
    end
  end

  assign stall = (credits == '0);

endmodule : outstanding_tracker

// File: request_arbiter.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module request_arbiter (
  input  logic                           ap_clk,
  input  logic                           control_areset,
  input  logic                           hold_off,
  input  logic [`GLAY_NUM_REQUESTORS-1:0] req_valid,
  input  glay_memory_pkg::glay_addr_t    req_base   [`GLAY_NUM_REQUESTORS],
  input  glay_memory_pkg::glay_addr_t    req_offset [`GLAY_NUM_REQUESTORS],
  output logic [`GLAY_NUM_REQUESTORS-1:0] grant,
  output logic                           win_valid,
  output glay_memory_pkg::glay_req_id_t  win_id,
  output glay_memory_pkg::glay_addr_t    win_base,
  output glay_memory_pkg::glay_addr_t    win_offset
);
  import glay_memory_pkg::*;

  glay_req_id_t last_id;
  glay_req_id_t pick_id;

  // ------------------------------
  // Round-robin pick
  // ------------------------------
  // Search starts one past the previous winner
  always_comb begin
    int   idx;
    logic found;
    grant   = '0;
    pick_id = last_id;
    found   = 1'b0;
    for (int k = 1; k <= `GLAY_NUM_REQUESTORS; k++) begin
      idx = (int'(last_id) + k) % `GLAY_NUM_REQUESTORS;
      if (!hold_off && !found && req_valid[idx]) begin
        grant[idx] = 1'b1;
        pick_id    = glay_req_id_t'(idx);
        found      = 1'b1;
      end
    end
  end

  // ------------------------------
  // Winner register
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      win_valid <= 1'b0;
      // Requestor 0 wins the first tie
      last_id   <= glay_req_id_t'(`GLAY_NUM_REQUESTORS - 1);
    end else begin
      win_valid <= |grant;
      if (|grant) begin
        last_id <= pick_id;
      end
    end
  end

  // Payload captured while the requestor still holds it
  always_ff @(posedge ap_clk) begin
    if (|grant) begin
      win_id     <= pick_id;
      win_base   <= req_base[pick_id];
      win_offset <= req_offset[pick_id];
    end
  end

endmodule : request_arbiter

// File: request_fifo.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module request_fifo (
  input  logic                          ap_clk,
  input  logic                          control_areset,
  input  logic                          wr_en,
  input  glay_memory_pkg::glay_req_id_t wr_id,
  input  glay_memory_pkg::glay_addr_t   wr_addr,
  input  logic                          rd_en,
  output glay_memory_pkg::glay_req_id_t rd_id,
  output glay_memory_pkg::glay_addr_t   rd_addr,
  output logic                          empty,
  output logic                          almost_full
);
  import glay_memory_pkg::*;

  localparam int PTR_W = $clog2(`GLAY_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`GLAY_FIFO_DEPTH + 1);

  // Entry storage
  glay_addr_t   addr_mem [`GLAY_FIFO_DEPTH];
  glay_req_id_t id_mem   [`GLAY_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // ------------------------------
  // Qualified pointer moves
  // ------------------------------
  assign push = wr_en && (count != CNT_W'(`GLAY_FIFO_DEPTH));
  assign pop  = rd_en && !empty;

  always_ff @(posedge ap_clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= wr_addr;
      id_mem[wr_ptr]   <= wr_id;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------
  // Head entry and flags
  // ------------------------------
  assign rd_addr = addr_mem[rd_ptr];
  assign rd_id   = id_mem[rd_ptr];
  assign empty   = (count == '0);

  // Rises early enough to absorb requests already in flight
  assign almost_full = (count >= CNT_W'(`GLAY_FIFO_DEPTH - `GLAY_FIFO_MARGIN));

endmodule : request_fifo

// File: run.sh
#!/usr/bin/env bash
# Build and run the cache request generator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f \
  --top-module tb_cache_request_generator \
  -o sim_tb

# The simulation's own status is not trusted, the output decides
sim_out=$(./obj_dir/sim_tb 2>&1) || true
echo "$sim_out"

if grep -q "TEST PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1

// File: tb_cache_request_generator.sv
`timescale 1ns/1ps
`include "glay_params.svh"

module tb_cache_request_generator;
  import glay_memory_pkg::*;
  import glay_control_pkg::*;

  // Requests per test summed for the watchdog
  localparam int TOTAL_REQUESTS = 4 + 40 + 20 + 6 + 12 + 12;
  localparam int TIMEOUT_CYCLES = TOTAL_REQUESTS * 20 + 200;
  // Grants before the queue backs up with two stages still in flight
  localparam int STALL_GRANTS = `GLAY_FIFO_DEPTH - `GLAY_FIFO_MARGIN + 2;

  logic                            ap_clk;
  logic                            control_areset;
  logic                            req_valid_q [`GLAY_NUM_REQUESTORS];
  logic [`GLAY_NUM_REQUESTORS-1:0] mem_req_valid;
  glay_addr_t                      base_q   [`GLAY_NUM_REQUESTORS];
  glay_addr_t                      offset_q [`GLAY_NUM_REQUESTORS];
  logic [`GLAY_NUM_REQUESTORS-1:0] mem_req_grant;
  logic                            cfg_wr_en;
  glay_cfg_reg_e                   cfg_addr;
  logic [`GLAY_ADDR_WIDTH-1:0]     cfg_wdata;
  logic                            cache_req_valid;
  glay_addr_t                      cache_req_addr;
  glay_req_id_t                    cache_req_id;
  logic                            cache_resp_valid;
  logic                            fifo_setup_signal;

  // Sequence control toward the checker
  int   test_num;
  logic test_done;
  logic check_en;
  int   expect_issues;
  int   expect_grants;
  int   test_issues;
  int   test_grants;
  int   pending;
  int   error_count;
  int   match_count;

  // Response model state
  bit          resp_auto;
  int          manual_resp;
  int          owed;
  logic [31:0] lcg_state;
  int          cycle_count;

  always_comb begin
    for (int i = 0; i < `GLAY_NUM_REQUESTORS; i++) begin
      mem_req_valid[i] = req_valid_q[i];
    end
  end

  cache_request_generator uut (
    .ap_clk                 (ap_clk),
    .control_areset         (control_areset),
    .mem_req_valid          (mem_req_valid),
    .mem_req_base_address   (base_q),
    .mem_req_address_offset (offset_q),
    .mem_req_grant          (mem_req_grant),
    .cfg_wr_en              (cfg_wr_en),
    .cfg_addr               (cfg_addr),
    .cfg_wdata              (cfg_wdata),
    .cache_req_valid        (cache_req_valid),
    .cache_req_addr         (cache_req_addr),
    .cache_req_id           (cache_req_id),
    .cache_resp_valid       (cache_resp_valid),
    .fifo_setup_signal      (fifo_setup_signal)
  );

  cache_req_checker u_req_checker (
    .ap_clk                 (ap_clk),
    .control_areset         (control_areset),
    .mem_req_valid          (mem_req_valid),
    .mem_req_base_address   (base_q),
    .mem_req_address_offset (offset_q),
    .mem_req_grant          (mem_req_grant),
    .cache_req_valid        (cache_req_valid),
    .cache_req_addr         (cache_req_addr),
    .cache_req_id           (cache_req_id),
    .fifo_setup_signal      (fifo_setup_signal),
    .test_num               (test_num),
    .test_done              (test_done),
    .check_en               (check_en),
    .expect_issues          (expect_issues),
    .expect_grants          (expect_grants),
    .test_issues            (test_issues),
    .test_grants            (test_grants),
    .pending                (pending),
    .error_count            (error_count),
    .match_count            (match_count)
  );

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // LCG for addresses and gaps
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Advance n edges and land just after the last one
  task automatic wait_cycles(int n);
    repeat (n) @(posedge ap_clk);
    #1;
  endtask

  task automatic write_cfg(glay_cfg_reg_e sel, logic [31:0] data);
    cfg_wr_en = 1'b1;
    cfg_addr  = sel;
    cfg_wdata = data;
    wait_cycles(1);
    cfg_wr_en = 1'b0;
    wait_cycles(2);
  endtask

  // One requestor holding each request until its grant pulse
  task automatic drive_requests(int idx, int count, bit gaps);
    int gap;
    for (int n = 0; n < count; n++) begin
      base_q[idx]      = lcg_next();
      offset_q[idx]    = lcg_next();
      req_valid_q[idx] = 1'b1;
      @(posedge ap_clk);
      while (!mem_req_grant[idx]) @(posedge ap_clk);
      #1;
      gap = gaps ? int'(lcg_next() % 32'd4) : 0;
      if (gap > 0) begin
        req_valid_q[idx] = 1'b0;
        wait_cycles(gap);
      end
    end
    req_valid_q[idx] = 1'b0;
  endtask

  task automatic run_pair(int count, bit gaps);
    fork
      drive_requests(0, count, gaps);
      drive_requests(1, count, gaps);
    join
  endtask

  task automatic expect_counts(int issues_exp, int grants_exp);
    expect_issues = issues_exp;
    expect_grants = grants_exp;
    check_en = 1'b1;
    wait_cycles(1);
    check_en = 1'b0;
  endtask

  // Drain queue and responses and then close the test
  task automatic finish_test();
    while ((pending != 0) || (owed != 0)) wait_cycles(1);
    test_done = 1'b1;
    wait_cycles(1);
    test_done = 1'b0;
  endtask

  // ------------------------------
  // Cache response model
  // ------------------------------
  initial begin
    cache_resp_valid = 1'b0;
    owed = 0;
    forever begin
      @(posedge ap_clk);
      if (cache_req_valid) owed++;
      #1;
      if ((owed > 0) && (resp_auto || (manual_resp > 0))) begin
        cache_resp_valid = 1'b1;
        owed--;
        if (!resp_auto) manual_resp--;
      end else begin
        cache_resp_valid = 1'b0;
      end
    end
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    for (int i = 0; i < `GLAY_NUM_REQUESTORS; i++) begin
      req_valid_q[i] = 1'b0;
      base_q[i]      = '0;
      offset_q[i]    = '0;
    end
    cfg_wr_en = 1'b0;
    cfg_addr = REG_CONTROL;
    cfg_wdata = '0;
    test_num = 0;
    test_done = 1'b0;
    check_en = 1'b0;
    expect_issues = 0;
    expect_grants = -1;
    resp_auto = 1'b1;
    manual_resp = 0;
    lcg_state = 32'd30;
    control_areset = 1'b1;
    repeat (16) @(posedge ap_clk);
    #1;
    control_areset = 1'b0;

    // Requests raised while setup is still running
    test_num = 1;
    fork
      run_pair(2, 1'b0);
      begin
        while (fifo_setup_signal) wait_cycles(1);
        write_cfg(REG_CONTROL, 32'd1);
      end
    join
    finish_test();

    test_num = 2;
    run_pair(20, 1'b1);
    finish_test();

    test_num = 3;
    run_pair(10, 1'b0);
    finish_test();

    // Credit limit 3 with responses withheld
    test_num = 4;
    resp_auto = 1'b0;
    write_cfg(REG_CREDIT_LIMIT, 32'd3);
    run_pair(3, 1'b0);
    while (test_issues < 3) wait_cycles(1);
    wait_cycles(20);
    expect_counts(3, -1);
    manual_resp++;
    wait_cycles(20);
    expect_counts(4, -1);
    manual_resp++;
    wait_cycles(20);
    expect_counts(5, -1);
    resp_auto = 1'b1;
    finish_test();

    // Issue gated off until the queue backs up
    test_num = 5;
    write_cfg(REG_CREDIT_LIMIT, 32'd16);
    write_cfg(REG_CONTROL, 32'd0);
    fork
      drive_requests(0, 6, 1'b0);
      drive_requests(1, 6, 1'b0);
      begin
        while (test_grants < STALL_GRANTS) wait_cycles(1);
        wait_cycles(20);
        expect_counts(0, STALL_GRANTS);
        write_cfg(REG_CONTROL, 32'd1);
      end
    join
    finish_test();

    // Two credits while the FIFO fills behind them
    test_num = 6;
    resp_auto = 1'b0;
    write_cfg(REG_CREDIT_LIMIT, 32'd2);
    fork
      drive_requests(0, 6, 1'b0);
      drive_requests(1, 6, 1'b0);
      begin
        while (test_grants < 2 + STALL_GRANTS) wait_cycles(1);
        wait_cycles(20);
        expect_counts(2, 2 + STALL_GRANTS);
        resp_auto = 1'b1;
      end
    join
    finish_test();

    $display("summary: 6 tests, %0d requests matched, %0d errors", match_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_cache_request_generator
